//--- hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and instruction widths
`define DATA_W      16
`define INST_W      16

// program counter counts instructions, not bytes
`define PC_W        16

// register file geometry
`define REG_COUNT   8
`define REG_ADDR_W  3

// first fetch address after reset
`define RESET_PC    16'h0000

`endif

//--- hw/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    // major opcode from instruction bits 15..11
    typedef enum logic [4:0] {
        OP_NOP   = 5'b00001,
        OP_B     = 5'b00010,
        OP_BEQZ  = 5'b00100,
        OP_BNEZ  = 5'b00101,
        OP_ADDIU = 5'b01001,
        OP_LI    = 5'b01101,
        OP_RRR   = 5'b11100,
        OP_RR    = 5'b11101
    } opcode_e;

    // function fields of the register forms
    localparam logic [1:0] FN_ADDU = 2'b01;
    localparam logic [1:0] FN_SUBU = 2'b11;
    localparam logic [4:0] FN_AND  = 5'b01100;
    localparam logic [4:0] FN_OR   = 5'b01101;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B
    } alu_op_e;

    // second ALU operand source
    typedef enum logic {
        B_REG,
        B_IMM
    } b_sel_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQZ,
        BR_NEZ,
        BR_ALWAYS
    } br_kind_e;

    typedef struct packed {
        alu_op_e                alu_op;
        b_sel_e                 b_sel;
        br_kind_e               br_kind;
        logic                   reg_write;
        logic [`REG_ADDR_W-1:0] dst;
    } dec_ctrl_t;

    // decode/execute register contents
    typedef struct packed {
        logic                   valid;
        logic [`PC_W-1:0]       pc;
        dec_ctrl_t              ctrl;
        logic [`REG_ADDR_W-1:0] rx_addr;
        logic [`REG_ADDR_W-1:0] ry_addr;
        logic [`DATA_W-1:0]     op_a;
        logic [`DATA_W-1:0]     op_b;
        logic [`DATA_W-1:0]     imm;
    } id_ex_t;

    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     data;
    } wb_t;

endpackage

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  logic               stall,
    input  logic [`INST_W-1:0] inst_data,
    output logic [`PC_W-1:0]   inst_addr,
    output cpu_pkg::wb_t       wb
);

    // fetch/decode register
    logic [`INST_W-1:0] if_inst;
    logic [`PC_W-1:0]   if_pc;
    logic               if_valid;

    cpu_pkg::id_ex_t    id_ex;

    // taken branch from execute
    logic               redirect;
    logic [`PC_W-1:0]   redirect_pc;

    fetch_unit u_fetch (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .stall       (stall),
        .inst_data   (inst_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_addr   (inst_addr),
        .if_inst     (if_inst),
        .if_pc       (if_pc),
        .if_valid    (if_valid)
    );

    decode_unit u_decode (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .if_inst   (if_inst),
        .if_pc     (if_pc),
        .if_valid  (if_valid),
        .redirect  (redirect),
        .wb        (wb),
        .id_ex     (id_ex)
    );

    execute_unit u_execute (
        .clk_50MHz   (clk_50MHz),
        .rst         (rst),
        .id_ex       (id_ex),
        .wb          (wb),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

endmodule

//--- hw/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_unit (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  logic [`INST_W-1:0] if_inst,
    input  logic [`PC_W-1:0]   if_pc,
    input  logic               if_valid,
    input  logic               redirect,
    input  cpu_pkg::wb_t       wb,
    output cpu_pkg::id_ex_t    id_ex
);

    cpu_pkg::opcode_e       opcode;
    cpu_pkg::dec_ctrl_t     ctrl;
    cpu_pkg::id_ex_t        id_ex_d;

    logic [`REG_ADDR_W-1:0] rx_addr;
    logic [`REG_ADDR_W-1:0] ry_addr;
    logic [`REG_ADDR_W-1:0] rz_addr;
    logic [`DATA_W-1:0]     rx_data;
    logic [`DATA_W-1:0]     ry_data;

    logic [`DATA_W-1:0]     imm_s8;
    logic [`DATA_W-1:0]     imm_z8;
    logic [`DATA_W-1:0]     imm_s11;
    logic [`DATA_W-1:0]     imm;

    assign opcode  = cpu_pkg::opcode_e'(if_inst[15:11]);
    assign rx_addr = if_inst[10:8];
    assign ry_addr = if_inst[7:5];
    assign rz_addr = if_inst[4:2];

    // immediate forms
    assign imm_s8  = {{(`DATA_W-8){if_inst[7]}}, if_inst[7:0]};
    assign imm_z8  = {{(`DATA_W-8){1'b0}}, if_inst[7:0]};
    assign imm_s11 = {{(`DATA_W-11){if_inst[10]}}, if_inst[10:0]};

    reg_file u_reg_file (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .rx_addr   (rx_addr),
        .ry_addr   (ry_addr),
        .wb        (wb),
        .rx_data   (rx_data),
        .ry_data   (ry_data)
    );

    always_comb begin
        // default is a NOP that writes nothing
        ctrl.alu_op    = cpu_pkg::ALU_ADD;
        ctrl.b_sel     = cpu_pkg::B_REG;
        ctrl.br_kind   = cpu_pkg::BR_NONE;
        ctrl.reg_write = 1'b0;
        ctrl.dst       = rx_addr;
        imm            = imm_s8;

        case (opcode)
            cpu_pkg::OP_ADDIU: begin
                ctrl.b_sel     = cpu_pkg::B_IMM;
                ctrl.reg_write = 1'b1;
            end
            cpu_pkg::OP_LI: begin
                ctrl.alu_op    = cpu_pkg::ALU_PASS_B;
                ctrl.b_sel     = cpu_pkg::B_IMM;
                ctrl.reg_write = 1'b1;
                imm            = imm_z8;
            end
            cpu_pkg::OP_RRR: begin
                ctrl.dst = rz_addr;
                if (if_inst[1:0] == cpu_pkg::FN_ADDU) begin
                    ctrl.reg_write = 1'b1;
                end else if (if_inst[1:0] == cpu_pkg::FN_SUBU) begin
                    ctrl.alu_op    = cpu_pkg::ALU_SUB;
                    ctrl.reg_write = 1'b1;
                end
            end
            cpu_pkg::OP_RR: begin
                if (if_inst[4:0] == cpu_pkg::FN_AND) begin
                    ctrl.alu_op    = cpu_pkg::ALU_AND;
                    ctrl.reg_write = 1'b1;
                end else if (if_inst[4:0] == cpu_pkg::FN_OR) begin
                    ctrl.alu_op    = cpu_pkg::ALU_OR;
                    ctrl.reg_write = 1'b1;
                end
            end
            cpu_pkg::OP_BEQZ: ctrl.br_kind = cpu_pkg::BR_EQZ;
            cpu_pkg::OP_BNEZ: ctrl.br_kind = cpu_pkg::BR_NEZ;
            cpu_pkg::OP_B: begin
                ctrl.br_kind = cpu_pkg::BR_ALWAYS;
                imm          = imm_s11;
            end
            default: ;
        endcase
    end

    always_comb begin
        id_ex_d.valid   = if_valid;
        id_ex_d.pc      = if_pc;
        id_ex_d.ctrl    = ctrl;
        id_ex_d.rx_addr = rx_addr;
        id_ex_d.ry_addr = ry_addr;
        id_ex_d.op_a    = rx_data;
        id_ex_d.op_b    = ry_data;
        id_ex_d.imm     = imm;
    end

    // a taken branch in execute kills the instruction decoded here
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            id_ex <= '0;
        end else if (redirect) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_unit (
    input  logic             clk_50MHz,
    input  logic             rst,
    input  cpu_pkg::id_ex_t  id_ex,
    output cpu_pkg::wb_t     wb,
    output logic             redirect,
    output logic [`PC_W-1:0] redirect_pc
);

    logic               fwd_a;
    logic               fwd_b;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] reg_b;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_y;
    logic               taken;

    // forward from the result register, one instruction ahead
    assign fwd_a = wb.valid && (wb.addr == id_ex.rx_addr);
    assign fwd_b = wb.valid && (wb.addr == id_ex.ry_addr);

    assign op_a  = fwd_a ? wb.data : id_ex.op_a;
    assign reg_b = fwd_b ? wb.data : id_ex.op_b;

    assign op_b  = (id_ex.ctrl.b_sel == cpu_pkg::B_IMM) ? id_ex.imm : reg_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            cpu_pkg::ALU_ADD:    alu_y = op_a + op_b;
            cpu_pkg::ALU_SUB:    alu_y = op_a - op_b;
            cpu_pkg::ALU_AND:    alu_y = op_a & op_b;
            cpu_pkg::ALU_OR:     alu_y = op_a | op_b;
            cpu_pkg::ALU_PASS_B: alu_y = op_b;
            default:             alu_y = op_b;
        endcase
    end

    // zero test on the forwarded rx value
    always_comb begin
        case (id_ex.ctrl.br_kind)
            cpu_pkg::BR_EQZ:    taken = (op_a == '0);
            cpu_pkg::BR_NEZ:    taken = (op_a != '0);
            cpu_pkg::BR_ALWAYS: taken = 1'b1;
            default:            taken = 1'b0;
        endcase
    end

    // target is relative to the instruction after the branch
    assign redirect    = id_ex.valid && taken;
    assign redirect_pc = id_ex.pc + `PC_W'(1) + `PC_W'(id_ex.imm);

    // result register, also the forwarding source
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            wb <= '0;
        end else begin
            wb.valid <= id_ex.valid && id_ex.ctrl.reg_write;
            wb.addr  <= id_ex.ctrl.dst;
            wb.data  <= alu_y;
        end
    end

endmodule

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_unit (
    input  logic               clk_50MHz,
    input  logic               rst,
    input  logic               stall,
    input  logic [`INST_W-1:0] inst_data,
    input  logic               redirect,
    input  logic [`PC_W-1:0]   redirect_pc,
    output logic [`PC_W-1:0]   inst_addr,
    output logic [`INST_W-1:0] if_inst,
    output logic [`PC_W-1:0]   if_pc,
    output logic               if_valid
);

    logic [`PC_W-1:0] pc;
    logic [`PC_W-1:0] pc_next;

    // redirect beats stall, otherwise the wrong path would be fetched
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + `PC_W'(1);
        end
    end

    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign inst_addr = pc;

    // bubble on flush or when memory is not ready
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= !(redirect || stall);
        end
    end

    // instruction and its address, qualified by if_valid
    always_ff @(posedge clk_50MHz) begin
        if_inst <= inst_data;
        if_pc   <= pc;
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module reg_file (
    input  logic                   clk_50MHz,
    input  logic                   rst,
    input  logic [`REG_ADDR_W-1:0] rx_addr,
    input  logic [`REG_ADDR_W-1:0] ry_addr,
    input  cpu_pkg::wb_t           wb,
    output logic [`DATA_W-1:0]     rx_data,
    output logic [`DATA_W-1:0]     ry_data
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    // r0 is a normal register here, not hardwired to zero
    always_ff @(posedge clk_50MHz or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // write-through so the reader two behind the writer sees new data
    assign rx_data = (wb.valid && (wb.addr == rx_addr)) ? wb.data : regs[rx_addr];
    assign ry_data = (wb.valid && (wb.addr == ry_addr)) ? wb.data : regs[ry_addr];

endmodule

//--- run.sh
#!/bin/sh
# compile and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cpu_tb -Mdir obj_dir -f verilog.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vcpu_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
fi
exit "$status"

//--- tests/cpu_asserts.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_asserts (
    input logic             clk_50MHz,
    input logic             rst,
    input logic             stall,
    input logic [`PC_W-1:0] inst_addr,
    input cpu_pkg::wb_t     wb,
    input logic             redirect,
    input logic [`PC_W-1:0] redirect_pc
);

    // reset state holds through reset and the first cycle after it
    reset_state: assert property (@(posedge clk_50MHz)
        !rst |=> (inst_addr == `RESET_PC) && !wb.valid && !redirect)
        else $error("fetch address, writeback or redirect not at reset state");

    stall_hold: assert property (@(posedge clk_50MHz) disable iff (!rst)
        rst && stall && !redirect |=> $stable(inst_addr))
        else $error("fetch address moved while stall was high");

    // plain sequential fetch
    fetch_step: assert property (@(posedge clk_50MHz) disable iff (!rst)
        rst && !stall && !redirect |=> inst_addr == $past(inst_addr) + `PC_W'(1))
        else $error("fetch address did not advance by one");

    redirect_target: assert property (@(posedge clk_50MHz) disable iff (!rst)
        redirect |=> inst_addr == $past(redirect_pc))
        else $error("fetch address did not load the branch target");

    // the branch and both younger instructions write nothing
    redirect_pulse: assert property (@(posedge clk_50MHz) disable iff (!rst)
        redirect |=> !redirect && !wb.valid)
        else $error("redirect longer than one cycle or branch wrote back");

    flush_second: assert property (@(posedge clk_50MHz) disable iff (!rst)
        $past(redirect, 2) |-> !wb.valid)
        else $error("flushed instruction wrote back");

    // the instruction dropped in fetch would retire one cycle later
    flush_third: assert property (@(posedge clk_50MHz) disable iff (!rst)
        $past(redirect, 3) |-> !wb.valid)
        else $error("second flushed instruction wrote back");

endmodule

bind cpu_top cpu_asserts u_asserts (
    .clk_50MHz   (clk_50MHz),
    .rst         (rst),
    .stall       (stall),
    .inst_addr   (inst_addr),
    .wb          (wb),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
);

//--- tests/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

    localparam logic [`INST_W-1:0] NOP_WORD = 16'h0800;

    // expected writeback and the pc of the instruction that made it
    typedef struct packed {
        logic [`PC_W-1:0]       pc;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`DATA_W-1:0]     data;
    } exp_t;

    logic               clk_50MHz = 1'b0;
    logic               rst = 1'b0;
    logic               stall = 1'b0;
    logic [`INST_W-1:0] inst_data;
    logic [`PC_W-1:0]   inst_addr;
    cpu_pkg::wb_t       wb;

    logic [`INST_W-1:0] rom [64];
    string              pc_test [64];
    string              cur_test;
    int                 prog_len = 0;
    int                 dyn_count;
    int                 cycles;
    int                 limit;
    int                 exp_idx = 0;
    exp_t               exp_q [$];
    logic [31:0]        prog_rng = 32'd77722;
    logic [31:0]        stall_rng = 32'd77722;

    cpu_top u_dut (
        .clk_50MHz (clk_50MHz),
        .rst       (rst),
        .stall     (stall),
        .inst_data (inst_data),
        .inst_addr (inst_addr),
        .wb        (wb)
    );

    always #10 clk_50MHz = ~clk_50MHz;

    // instruction memory, NOP past the end of the program
    assign inst_data = (int'(inst_addr) < prog_len) ? rom[inst_addr[5:0]] : NOP_WORD;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] rand_byte();
        prog_rng = xorshift32(prog_rng);
        return prog_rng[7:0];
    endfunction

    function automatic logic [`INST_W-1:0] encode(input logic [4:0] op, input logic [10:0] f);
        return {op, f};
    endfunction

    task automatic emit(input logic [`INST_W-1:0] w);
        rom[prog_len]     = w;
        pc_test[prog_len] = cur_test;
        prog_len++;
    endtask

    task automatic build_program();
        int         loop_pc;
        logic [7:0] off;
        cur_test = "alu_chain";
        emit(encode(5'b01101, {3'd1, rand_byte()}));
        emit(encode(5'b01101, {3'd2, rand_byte()}));
        emit(encode(5'b11100, {3'd1, 3'd2, 3'd3, 2'b01}));
        emit(encode(5'b11100, {3'd3, 3'd1, 3'd4, 2'b11}));
        emit(encode(5'b11101, {3'd4, 3'd3, 5'b01100}));
        emit(encode(5'b11101, {3'd3, 3'd4, 5'b01101}));
        emit(encode(5'b01001, {3'd0, rand_byte()}));
        emit(encode(5'b11100, {3'd0, 3'd4, 3'd5, 2'b01}));
        emit(NOP_WORD);
        // r5 written two ahead, read through the register file
        emit(encode(5'b11100, {3'd5, 3'd3, 3'd6, 2'b11}));
        cur_test = "branches";
        emit(encode(5'b01101, {3'd7, 8'h00}));
        emit(encode(5'b00100, {3'd7, 8'd2}));
        emit(encode(5'b01101, {3'd1, 8'hAA}));
        emit(encode(5'b01101, {3'd2, 8'hBB}));
        emit(encode(5'b01101, {3'd6, rand_byte() | 8'h01}));
        emit(encode(5'b00100, {3'd6, 8'd1}));
        emit(encode(5'b01001, {3'd6, 8'd1}));
        emit(encode(5'b00101, {3'd6, 8'd1}));
        emit(encode(5'b01001, {3'd1, 8'd3}));
        emit(encode(5'b00101, {3'd7, 8'd1}));
        emit(encode(5'b00010, 11'd2));
        emit(encode(5'b01101, {3'd5, 8'd1}));
        emit(encode(5'b01101, {3'd4, 8'd2}));
        emit(encode(5'b11100, {3'd6, 3'd3, 3'd1, 2'b01}));
        cur_test = "loop";
        emit(encode(5'b01101, {3'd2, (rand_byte() & 8'd3) + 8'd2}));
        emit(encode(5'b01101, {3'd3, 8'h00}));
        loop_pc = prog_len;
        emit(encode(5'b01001, {3'd3, rand_byte()}));
        emit(encode(5'b01001, {3'd2, 8'hFF}));
        off = 8'(loop_pc - prog_len - 1);
        emit(encode(5'b00101, {3'd2, off}));
        emit(encode(5'b11101, {3'd3, 3'd2, 5'b01101}));
    endtask

    // sequential ISA model, one instruction per step
    task automatic run_model();
        logic [`DATA_W-1:0] regs [`REG_COUNT];
        logic [`PC_W-1:0]   pc;
        logic [`PC_W-1:0]   npc;
        logic [`INST_W-1:0] w;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] s8;
        logic               wr;
        exp_t               e;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] = '0;
        end
        pc = `RESET_PC;
        dyn_count = 0;
        while (int'(pc) < prog_len && dyn_count < 1000) begin
            w      = rom[pc[5:0]];
            a      = regs[w[10:8]];
            b      = regs[w[7:5]];
            s8     = {{8{w[7]}}, w[7:0]};
            npc    = pc + `PC_W'(1);
            wr     = 1'b0;
            e.pc   = pc;
            e.addr = w[10:8];
            e.data = '0;
            case (w[15:11])
                5'b01001: begin
                    wr     = 1'b1;
                    e.data = a + s8;
                end
                5'b01101: begin
                    wr     = 1'b1;
                    e.data = {8'h00, w[7:0]};
                end
                5'b11100: begin
                    wr     = (w[1:0] == 2'b01) || (w[1:0] == 2'b11);
                    e.addr = w[4:2];
                    e.data = w[1] ? a - b : a + b;
                end
                5'b11101: begin
                    wr     = (w[4:1] == 4'b0110);
                    e.data = w[0] ? (a | b) : (a & b);
                end
                5'b00100: npc = (a == '0) ? pc + `PC_W'(1) + s8 : npc;
                5'b00101: npc = (a != '0) ? pc + `PC_W'(1) + s8 : npc;
                5'b00010: npc = pc + `PC_W'(1) + {{5{w[10]}}, w[10:0]};
                default: ;
            endcase
            if (wr) begin
                regs[e.addr] = e.data;
                exp_q.push_back(e);
            end
            pc = npc;
            dyn_count++;
        end
    endtask

    task automatic check_writeback();
        exp_t e;
        assert (exp_idx < exp_q.size()) else begin
            $display("Unexpected writeback to r%0d after all expected results were seen",
                     wb.addr);
            $display("TEST FAILED");
            $fatal(1, "extra writeback");
        end
        e = exp_q[exp_idx];
        assert (wb.addr == e.addr && wb.data == e.data) else begin
            $display("Mismatch in %s at pc %0d: expected r%0d=%h, actual r%0d=%h",
                     pc_test[e.pc[5:0]], e.pc, e.addr, e.data, wb.addr, wb.data);
            $display("TEST FAILED");
            $fatal(1, "writeback mismatch");
        end
        exp_idx++;
    endtask

    // memory wait states, roughly one cycle in five
    always @(posedge clk_50MHz) begin
        if (!rst) begin
            stall <= 1'b0;
        end else begin
            stall_rng = xorshift32(stall_rng);
            stall <= (stall_rng % 5) == 0;
        end
    end

    always @(negedge clk_50MHz) begin
        if (wb.valid) begin
            check_writeback();
        end
    end

    initial begin
        build_program();
        run_model();
        limit  = (dyn_count * 3 + 50) * 2;
        cycles = 0;
        repeat (10) @(posedge clk_50MHz);
        rst <= 1'b1;
        // run until all results retired and fetch is past the program
        while (cycles < limit &&
               !(exp_idx == exp_q.size() && int'(inst_addr) >= prog_len + 4)) begin
            @(negedge clk_50MHz);
            cycles++;
        end
        if (cycles >= limit) begin
            $display("TEST FAILED");
            $fatal(1, "timeout after %0d cycles, %0d of %0d results seen",
                   cycles, exp_idx, exp_q.size());
        end else begin
            // idle cycles to catch stray writebacks
            repeat (8) @(posedge clk_50MHz);
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+hw
hw/cpu_pkg.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/cpu_top.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv
